/* all.f */
+incdir+verif
rtl/hbridge_pkg.sv
rtl/adc_capture.sv
rtl/startup_seq.sv
rtl/dead_time.sv
rtl/gate_drive.sv
rtl/hbridge_top.sv
verif/tb_hbridge_top.sv

/* rtl/adc_capture.sv */
// samples on the DCO rising edge; the board inverts tank polarity, so every word is negated
module adc_capture (
   input  logic                             i_clk_dco,
   input  logic                             i_rst_n,
   input  logic signed [hbridge_pkg::ADC_W-1:0] i_data,
   input  logic                             i_or,
   output hbridge_pkg::adc_sample_t         o_sample
);
   import hbridge_pkg::*;

   // next sample value before the register
   logic signed [ADC_W-1:0] value_d;

   // ============================================================
   // conditioning
   // ============================================================

   // in range: two's complement negation
   // the raw negative-full code never shows up here without OR,
   // so the wrap of -(-8192) is not a concern
   //
   // over range: fold to a full-scale value
   // raw negative full flips to positive full,
   // anything else is taken as the positive rail and flips negative
   always_comb begin
      if (i_or) begin
         if (i_data == ADC_NEG_FULL) begin
            value_d = ADC_POS_FULL;
         end else begin
            value_d = ADC_NEG_FULL;
         end
      end else begin
         value_d = -i_data;
      end
   end

   // ============================================================
   // capture register
   // ============================================================

   // one cycle from raw word to sample
   // flag and value travel together so the controller
   // sees them from the same conversion
   always_ff @(posedge i_clk_dco) begin
      if (!i_rst_n) begin
         o_sample <= '0;
      end else begin
         // flag follows the pin directly
         o_sample.over_range <= i_or;
         o_sample.value      <= value_d;
      end
   end

endmodule

/* rtl/dead_time.sv */
// rising-edge delay only, falls pass after one register; each DTn must be at least 1
module dead_time #(
   parameter int DT0 = 80,
   parameter int DT1 = 40,
   parameter int DT2 = 20,
   parameter int DT3 = 60
) (
   input  logic                                ADA_DCO,
   input  logic                                i_rst_n,
   input  logic [hbridge_pkg::DT_SEL_W-1:0]    i_dt_sel,
   input  hbridge_pkg::gate_set_t              i_cmd,
   output hbridge_pkg::gate_set_t              o_gates
);
   import hbridge_pkg::*;

   // largest of the four delays, sets the counter width
   function automatic int max_of4(input int a, input int b, input int c, input int d);
      int m;
      m = a;
      if (b > m) begin
         m = b;
      end
      if (c > m) begin
         m = c;
      end
      if (d > m) begin
         m = d;
      end
      return m;
   endfunction

   localparam int DT_MAX  = max_of4(DT0, DT1, DT2, DT3);
   localparam int CNT_W   = $clog2(DT_MAX + 1);
   localparam int N_GATES = $bits(gate_set_t);

   // selected delay in cycles
   logic [CNT_W-1:0]   dly;
   // struct flattened to one bit per gate
   logic [N_GATES-1:0] cmd_bits;
   logic [N_GATES-1:0] gate_bits;

   // ============================================================
   // delay select
   // ============================================================

   always_comb begin
      case (i_dt_sel)
         2'd0:    dly = CNT_W'(DT0);
         2'd1:    dly = CNT_W'(DT1);
         2'd2:    dly = CNT_W'(DT2);
         2'd3:    dly = CNT_W'(DT3);
         default: dly = CNT_W'(DT0);
      endcase
   end

   assign cmd_bits = i_cmd;
   assign o_gates  = gate_bits;

   // ============================================================
   // per-gate high-time counters
   // ============================================================

   for (genvar g = 0; g < N_GATES; g++) begin : g_gate
      // consecutive high samples of this gate's command
      logic [CNT_W-1:0] hi_cnt;
      // one bit wider so the compare never wraps
      logic [CNT_W:0]   hi_cnt_inc;
      logic             gate_r;

      assign hi_cnt_inc = {1'b0, hi_cnt} + 1'b1;

      // low command: counter and gate drop on the same edge
      // high command: count up to the delay, then hold
      // gate sets on the D-th consecutive high sample
      always_ff @(posedge ADA_DCO) begin
         if (!i_rst_n) begin
            hi_cnt <= '0;
            gate_r <= 1'b0;
         end else if (!cmd_bits[g]) begin
            hi_cnt <= '0;
            gate_r <= 1'b0;
         end else begin
            if (hi_cnt < dly) begin
               hi_cnt <= hi_cnt_inc[CNT_W-1:0];
            end
            if (hi_cnt_inc >= {1'b0, dly}) begin
               gate_r <= 1'b1;
            end
         end
      end

      assign gate_bits[g] = gate_r;
   end

endmodule

/* rtl/gate_drive.sv */
// shoot-through check looks at the dead-time outputs only; start-up patterns are fixed
module gate_drive (
   input  logic                   ADA_DCO,
   input  logic                   i_rst_n,
   input  logic                   i_enable,
   input  logic                   i_on,
   input  logic                   i_vg,
   input  hbridge_pkg::gate_set_t i_gates,
   output hbridge_pkg::gate_set_t o_q
);
   import hbridge_pkg::*;

   // bootstrap: both low sides on to charge the caps
   localparam gate_set_t BOOT_PAT = '{q4: 1'b1, q3: 1'b1, q2: 1'b0, q1: 1'b0};
   // pre-charge: diagonal q1/q4 to load the tank
   localparam gate_set_t PRECHG_PAT = '{q4: 1'b1, q3: 1'b0, q2: 1'b0, q1: 1'b1};

   gate_set_t pat;
   logic      shoot_thru;

   // ============================================================
   // pattern select and blanking
   // ============================================================

   always_comb begin
      if (!i_on) begin
         pat = BOOT_PAT;
      end else if (!i_vg) begin
         pat = PRECHG_PAT;
      end else begin
         pat = i_gates;
      end
   end

   // both switches of one leg high
   assign shoot_thru = (i_gates.q1 & i_gates.q3) | (i_gates.q2 & i_gates.q4);

   // output register, all off when disabled or on a bad pattern
   always_ff @(posedge ADA_DCO) begin
      if (!i_rst_n) begin
         o_q <= '0;
      end else if (!i_enable || shoot_thru) begin
         o_q <= '0;
      end else begin
         o_q <= pat;
      end
   end

endmodule

/* rtl/hbridge_pkg.sv */
// one clock domain on ADA_DCO; ADC words are two's complement (converter DFS pin tied high)
package hbridge_pkg;

   // ============================================================
   // tank ADC data format
   // ============================================================

   // raw converter word width, both channels
   localparam int ADC_W = 14;

   // most positive code, 0x1FFF for 14 bits
   // used when the raw word sits at negative full scale in over-range,
   // which becomes positive full scale after the polarity flip
   localparam logic signed [ADC_W-1:0] ADC_POS_FULL = {1'b0, {(ADC_W-1){1'b1}}};

   // most negative code, 0x2000 for 14 bits
   // also the raw negative-full code that the converter reports
   // any other over-range folds to this value
   localparam logic signed [ADC_W-1:0] ADC_NEG_FULL = {1'b1, {(ADC_W-1){1'b0}}};

   // ============================================================
   // dead-time select
   // ============================================================

   // four run-time choices of rising-edge delay
   localparam int DT_SEL_W = 2;

   // ============================================================
   // shared structs
   // ============================================================

   // one bit per MOSFET, q1 lands on bit 0
   // leg 1 is q1 (high side) with q3 (low side)
   // leg 2 is q2 (high side) with q4 (low side)
   // q1 and q3 must never be on together, same for q2 and q4
   typedef struct packed {
      logic q4;
      logic q3;
      logic q2;
      logic q1;
   } gate_set_t;

   // conditioned tank sample
   // over_range mirrors the converter OR pin for the same word
   // value is already polarity corrected and folded
   typedef struct packed {
      logic                    over_range;
      logic signed [ADC_W-1:0] value;
   } adc_sample_t;

endpackage

/* rtl/hbridge_top.sv */
// switching pattern comes from an external controller; fall reaches o_q in 2 cycles, rise in D+1
module hbridge_top #(
   parameter int ON_COUNT = 10,
   parameter int VG_COUNT = 14,
   parameter int DT0      = 80,
   parameter int DT1      = 40,
   parameter int DT2      = 20,
   parameter int DT3      = 60
) (
   input  logic                                 ADA_DCO,
   input  logic                                 i_rst_n,
   // tank ADCs, A is voltage, B is current
   input  logic signed [hbridge_pkg::ADC_W-1:0] i_adc_a_data,
   input  logic signed [hbridge_pkg::ADC_W-1:0] i_adc_b_data,
   input  logic                                 i_adc_a_or,
   input  logic                                 i_adc_b_or,
   // converter control
   input  logic                                 i_enable,
   input  logic [hbridge_pkg::DT_SEL_W-1:0]     i_dt_sel,
   input  hbridge_pkg::gate_set_t               i_switch_cmd,
   // conditioned samples to the controller
   output hbridge_pkg::adc_sample_t             o_vc,
   output hbridge_pkg::adc_sample_t             o_ic,
   // MOSFET gates
   output hbridge_pkg::gate_set_t               o_q
);
   import hbridge_pkg::*;

   // start-up phase levels
   logic      on;
   logic      vg;
   // command after dead time
   gate_set_t dt_gates;

   // ============================================================
   // input side, tank capture
   // ============================================================

   // tank voltage
   adc_capture u_adc_vc (
      .i_clk_dco (ADA_DCO),
      .i_rst_n   (i_rst_n),
      .i_data    (i_adc_a_data),
      .i_or      (i_adc_a_or),
      .o_sample  (o_vc)
   );

   // tank current
   adc_capture u_adc_ic (
      .i_clk_dco (ADA_DCO),
      .i_rst_n   (i_rst_n),
      .i_data    (i_adc_b_data),
      .i_or      (i_adc_b_or),
      .o_sample  (o_ic)
   );

   // ============================================================
   // processing, start-up and dead time
   // ============================================================

   startup_seq #(
      .ON_COUNT (ON_COUNT),
      .VG_COUNT (VG_COUNT)
   ) u_startup (
      .ADA_DCO  (ADA_DCO),
      .i_rst_n  (i_rst_n),
      .i_enable (i_enable),
      .o_on     (on),
      .o_vg     (vg)
   );

   dead_time #(
      .DT0 (DT0),
      .DT1 (DT1),
      .DT2 (DT2),
      .DT3 (DT3)
   ) u_dead_time (
      .ADA_DCO  (ADA_DCO),
      .i_rst_n  (i_rst_n),
      .i_dt_sel (i_dt_sel),
      .i_cmd    (i_switch_cmd),
      .o_gates  (dt_gates)
   );

   // output side, final gate logic
   gate_drive u_gate_drive (
      .ADA_DCO  (ADA_DCO),
      .i_rst_n  (i_rst_n),
      .i_enable (i_enable),
      .i_on     (on),
      .i_vg     (vg),
      .i_gates  (dt_gates),
      .o_q      (o_q)
   );

endmodule

/* rtl/startup_seq.sv */
// 8-bit bootstrap counter; needs ON_COUNT < VG_COUNT < 255 or the levels never rise
module startup_seq #(
   parameter int ON_COUNT = 10,
   parameter int VG_COUNT = 14
) (
   input  logic ADA_DCO,
   input  logic i_rst_n,
   input  logic i_enable,
   output logic o_on,
   output logic o_vg
);

   // counter width, matches the board sequencer
   localparam int CNT_W = 8;

   // thresholds at counter width
   localparam logic [CNT_W-1:0] ON_LIM = CNT_W'(ON_COUNT);
   localparam logic [CNT_W-1:0] VG_LIM = CNT_W'(VG_COUNT);

   logic [CNT_W-1:0] boot_cnt;

   // ============================================================
   // bootstrap counter
   // ============================================================

   // clears whenever enable is low, so a re-enable always
   // starts the sequence over from the bootstrap phase
   // runs while enabled and gate-valid is not yet reached
   // then freezes at VG_COUNT+1
   always_ff @(posedge ADA_DCO) begin
      if (!i_rst_n) begin
         boot_cnt <= '0;
      end else if (!i_enable) begin
         boot_cnt <= '0;
      end else if (!o_vg) begin
         boot_cnt <= boot_cnt + 1'b1;
      end
   end

   // ============================================================
   // phase levels
   // ============================================================

   // on: bootstrap caps charged, leave low-side pattern
   // first enabled edge E gives count 1, so on
   // rises right after edge E+ON_COUNT
   assign o_on = (boot_cnt > ON_LIM);

   // vg: pre-charge done, gates follow the command
   // rises right after edge E+VG_COUNT
   assign o_vg = (boot_cnt > VG_LIM);

endmodule

/* verif/tb_hbridge_tasks.svh */
// included inside tb_hbridge_top; inputs driven and outputs checked 1 ns after a rising edge

// ============================================================
// helpers and reference rules
// ============================================================

// full-scale codes in 14-bit two's complement
localparam logic signed [13:0] POS_FULL = 14'h1fff;
localparam logic signed [13:0] NEG_FULL = 14'h2000;
localparam gate_set_t BOOT_GATES   = gate_set_t'(4'b1100);
localparam gate_set_t PRECHG_GATES = gate_set_t'(4'b1001);

// 1 ns past the next rising edge
task automatic next_cycle();
   @(posedge ADA_DCO);
   #1;
endtask

task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
   checks_run++;
   if (got !== exp) begin
      error_count++;
      $display("MISMATCH at %0d ns: %s, got %0h expected %0h", $time, what, got, exp);
   end
endtask

function automatic int dt_value(input int sel);
   int d;
   case (sel)
      0: d = DT0;
      1: d = DT1;
      2: d = DT2;
      default: d = DT3;
   endcase
   return d;
endfunction

// o_q after edge E+n where edge E first sees enable high
// command driven after edge E reaches o_q after E+d+1
function automatic gate_set_t startup_expect(input int n, input int d, input gate_set_t cmd);
   gate_set_t q;
   if (n <= ON_COUNT) begin
      q = BOOT_GATES;
   end else if (n <= VG_COUNT) begin
      q = PRECHG_GATES;
   end else if (n >= d + 1) begin
      q = cmd;
   end else begin
      q = '0;
   end
   return q;
endfunction

// ============================================================
// tests
// ============================================================

task automatic test_reset_state();
   check_equal(o_q, 32'h0, "gates after reset");
   check_equal(o_vc, 32'h0, "tank voltage after reset");
   check_equal(o_ic, 32'h0, "tank current after reset");
endtask

task automatic test_adc_capture();
   logic signed [13:0] raw_a;
   logic signed [13:0] raw_b;
   adc_sample_t        exp_a;
   adc_sample_t        exp_b;
   int                 i;
   // in-range words come back negated one cycle later
   for (i = 0; i < ADC_WORDS; i++) begin
      raw_a = 14'($urandom);
      raw_b = 14'($urandom);
      // negative-full only comes with over-range
      if (raw_a == NEG_FULL) begin
         raw_a = 14'sd1;
      end
      if (raw_b == NEG_FULL) begin
         raw_b = -14'sd1;
      end
      i_adc_a_data = raw_a;
      i_adc_b_data = raw_b;
      i_adc_a_or   = 1'b0;
      i_adc_b_or   = 1'b0;
      exp_a.over_range = 1'b0;
      exp_a.value      = -raw_a;
      exp_b.over_range = 1'b0;
      exp_b.value      = -raw_b;
      next_cycle();
      check_equal(o_vc, exp_a, "tank voltage in range");
      check_equal(o_ic, exp_b, "tank current in range");
   end
   // over-range fold with both code classes on each channel
   for (i = 0; i < 2; i++) begin
      raw_b = (i == 0) ? POS_FULL : 14'($urandom % 4096);
      i_adc_a_data = (i == 0) ? NEG_FULL : raw_b;
      i_adc_b_data = (i == 0) ? raw_b : NEG_FULL;
      i_adc_a_or   = 1'b1;
      i_adc_b_or   = 1'b1;
      next_cycle();
      check_equal(o_vc, (i == 0) ? {1'b1, POS_FULL} : {1'b1, NEG_FULL}, "voltage over-range");
      check_equal(o_ic, (i == 0) ? {1'b1, NEG_FULL} : {1'b1, POS_FULL}, "current over-range");
   end
   i_adc_a_or = 1'b0;
   i_adc_b_or = 1'b0;
endtask

task automatic test_startup(input string tag);
   gate_set_t cmd;
   int        n;
   cmd          = gate_set_t'(4'b0010);
   i_dt_sel     = 2'd0;
   i_switch_cmd = '0;
   i_enable     = 1'b1;
   next_cycle();
   check_equal(o_q, startup_expect(0, DT0, cmd), {tag, ": bootstrap at first edge"});
   // q2 command while still starting up
   i_switch_cmd = cmd;
   for (n = 1; n <= VG_COUNT + 3; n++) begin
      next_cycle();
      check_equal(o_q, startup_expect(n, DT0, cmd), $sformatf("%s: phase at edge E+%0d", tag, n));
   end
endtask

task automatic test_dead_time(input int sel);
   int        d;
   int        k;
   gate_set_t one_gate;
   d        = dt_value(sel);
   one_gate = gate_set_t'(4'b0001 << ($urandom % 4));
   i_dt_sel     = sel[DT_SEL_W-1:0];
   i_switch_cmd = '0;
   repeat (d + 2) next_cycle();
   check_equal(o_q, 32'h0, $sformatf("sel %0d: idle before rise", sel));
   i_switch_cmd = one_gate;
   for (k = 1; k <= d; k++) begin
      next_cycle();
      check_equal(o_q, 32'h0, $sformatf("sel %0d: rise held off, cycle %0d", sel, k));
   end
   next_cycle();
   check_equal(o_q, one_gate, $sformatf("sel %0d: rise after D+1", sel));
   repeat (2) next_cycle();
   check_equal(o_q, one_gate, $sformatf("sel %0d: gate held", sel));
   i_switch_cmd = '0;
   next_cycle();
   check_equal(o_q, one_gate, $sformatf("sel %0d: gate one cycle after fall", sel));
   next_cycle();
   check_equal(o_q, 32'h0, $sformatf("sel %0d: fall after 2", sel));
   // pulse of D-1 samples is swallowed
   i_switch_cmd = one_gate;
   for (k = 1; k < d; k++) begin
      next_cycle();
      check_equal(o_q, 32'h0, $sformatf("sel %0d: short pulse high", sel));
   end
   i_switch_cmd = '0;
   for (k = 0; k < d + 2; k++) begin
      next_cycle();
      check_equal(o_q, 32'h0, $sformatf("sel %0d: short pulse after", sel));
   end
endtask

task automatic test_shoot_through(input int sel, input gate_set_t pair);
   int d;
   int k;
   d            = dt_value(sel);
   i_dt_sel     = sel[DT_SEL_W-1:0];
   i_switch_cmd = pair;
   for (k = 1; k <= d + 3; k++) begin
      next_cycle();
      check_equal(o_q, 32'h0, $sformatf("sel %0d: blanking of %b", sel, pair));
   end
   i_switch_cmd = '0;
   repeat (2) next_cycle();
   check_equal(o_q, 32'h0, $sformatf("sel %0d: idle after %b", sel, pair));
endtask

task automatic test_enable_drop();
   int k;
   i_dt_sel     = 2'd0;
   i_switch_cmd = gate_set_t'(4'b0001);
   repeat (DT0 + 1) next_cycle();
   check_equal(o_q, 32'h1, "q1 before enable drop");
   i_enable = 1'b0;
   for (k = 0; k < 4; k++) begin
      next_cycle();
      check_equal(o_q, 32'h0, "gates with enable low");
   end
   test_startup("re-enable");
endtask

/* verif/tb_hbridge_top.sv */
// small start-up counts and dead times keep the run short; gates, samples and phases checked
module tb_hbridge_top;
   timeunit 1ns;
   timeprecision 1ps;
   import hbridge_pkg::*;

   // ============================================================
   // test setup
   // ============================================================

   localparam int CLK_PERIOD = 8;
   localparam int ON_COUNT   = 3;
   localparam int VG_COUNT   = 6;
   localparam int DT0        = 2;
   localparam int DT1        = 3;
   localparam int DT2        = 4;
   localparam int DT3        = 5;
   localparam int DT_MAX     = 5;
   localparam int ADC_WORDS  = 20;

   // rough cycle budget per test, summed
   localparam int RUN_CYCLES = 2 + (ADC_WORDS + 6) + 2 * (VG_COUNT + 5)
                               + 4 * (4 * DT_MAX + 8) + 8 * (DT_MAX + 6) + (DT_MAX + 8);
   // twice the budget for margin
   localparam int TIMEOUT_NS = 2 * RUN_CYCLES * CLK_PERIOD;

   logic                    ADA_DCO;
   logic                    i_rst_n;
   logic signed [ADC_W-1:0] i_adc_a_data;
   logic signed [ADC_W-1:0] i_adc_b_data;
   logic                    i_adc_a_or;
   logic                    i_adc_b_or;
   logic                    i_enable;
   logic [DT_SEL_W-1:0]     i_dt_sel;
   gate_set_t               i_switch_cmd;
   adc_sample_t             o_vc;
   adc_sample_t             o_ic;
   gate_set_t               o_q;

   int error_count = 0;
   int checks_run  = 0;

   hbridge_top #(
      .ON_COUNT (ON_COUNT),
      .VG_COUNT (VG_COUNT),
      .DT0      (DT0),
      .DT1      (DT1),
      .DT2      (DT2),
      .DT3      (DT3)
   ) i_dut (
      .ADA_DCO      (ADA_DCO),
      .i_rst_n      (i_rst_n),
      .i_adc_a_data (i_adc_a_data),
      .i_adc_b_data (i_adc_b_data),
      .i_adc_a_or   (i_adc_a_or),
      .i_adc_b_or   (i_adc_b_or),
      .i_enable     (i_enable),
      .i_dt_sel     (i_dt_sel),
      .i_switch_cmd (i_switch_cmd),
      .o_vc         (o_vc),
      .o_ic         (o_ic),
      .o_q          (o_q)
   );

   `include "tb_hbridge_tasks.svh"

   // 8 ns clock
   initial begin
      ADA_DCO = 1'b0;
      forever #(CLK_PERIOD / 2) ADA_DCO = ~ADA_DCO;
   end

   // watchdog
   initial begin
      #(TIMEOUT_NS);
      $display("watchdog: tests did not finish within %0d ns", TIMEOUT_NS);
      $display("FAIL: see errors above");
      $finish;
   end

   // ============================================================
   // test sequence
   // ============================================================

   initial begin
      int sel;
      void'($urandom(32'hfa8e));
      i_rst_n      = 1'b0;
      i_adc_a_data = '0;
      i_adc_b_data = '0;
      i_adc_a_or   = 1'b0;
      i_adc_b_or   = 1'b0;
      i_enable     = 1'b0;
      i_dt_sel     = '0;
      i_switch_cmd = '0;
      // reset held for two edges
      repeat (2) @(posedge ADA_DCO);
      #1;
      i_rst_n = 1'b1;
      test_reset_state();
      test_adc_capture();
      test_startup("first enable");
      for (sel = 0; sel < 4; sel++) begin
         test_dead_time(sel);
      end
      for (sel = 0; sel < 4; sel++) begin
         test_shoot_through(sel, gate_set_t'(4'b0101));
         test_shoot_through(sel, gate_set_t'(4'b1010));
      end
      test_enable_drop();
      $display("checks run: %0d, errors: %0d", checks_run, error_count);
      if (error_count == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule
